/* rtl/iq_types_pkg.sv */
// iq data path types
// sample, coefficient and product widths of the receive correction path
// plus the sample pair and stream structs passed between blocks

package iq_types_pkg;

  // fixed point layout of the correction coefficients
  localparam int COEFF_FRAC = 14;

  // converter sample, two's complement
  typedef logic signed [15:0] sample_t;

  // correction coefficient with COEFF_FRAC fractional bits
  typedef logic signed [15:0] coeff_t;

  // full width product and sum
  typedef logic signed [33:0] prod_t;

  // one complex sample
  typedef struct packed {
    sample_t i;
    sample_t q;
  } iq_pair_t;

  // complex sample plus its strobe
  typedef struct packed {
    logic     valid;
    iq_pair_t data;
  } iq_stream_t;

endpackage

/* rtl/iq_regs_pkg.sv */
// iq correction register map
// addresses of the configuration registers, ctrl bit positions
// and the configuration struct handed out by the register file

package iq_regs_pkg;

  import iq_types_pkg::*;

  typedef logic [3:0]  reg_addr_t;
  typedef logic [15:0] reg_data_t;

  // register addresses
  localparam reg_addr_t ADDR_CTRL     = 4'd0;
  localparam reg_addr_t ADDR_DC_I     = 4'd1;
  localparam reg_addr_t ADDR_DC_Q     = 4'd2;
  localparam reg_addr_t ADDR_COEFF_II = 4'd3;
  localparam reg_addr_t ADDR_COEFF_IQ = 4'd4;
  localparam reg_addr_t ADDR_COEFF_QI = 4'd5;
  localparam reg_addr_t ADDR_COEFF_QQ = 4'd6;
  localparam reg_addr_t ADDR_LAST     = 4'd6;

  // ctrl register bits
  localparam int CTRL_IQCOR_BIT = 0;
  localparam int CTRL_DC_BIT    = 1;

  // full configuration as seen by the data path
  typedef struct packed {
    logic    iqcor_en;
    logic    dc_en;
    sample_t dc_i;
    sample_t dc_q;
    coeff_t  coeff_ii;
    coeff_t  coeff_iq;
    coeff_t  coeff_qi;
    coeff_t  coeff_qq;
  } iq_cfg_t;

endpackage

/* rtl/iq_mul.sv */
// signed multiplier for the iq correction
// operands sign extended and registered, product registered
// side data delayed alongside so it stays aligned with the product

`timescale 1ns/1ps

module iq_mul import iq_types_pkg::*; #(
  parameter int delay_width = 16
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  sample_t                data_a,
  input  coeff_t                 data_b,
  input  logic [delay_width-1:0] ddata_in,
  output prod_t                  data_p,
  output logic [delay_width-1:0] ddata_out
);

  // stage 1 operands, one bit of sign extension each
  logic signed [16:0] a_ext_r;
  logic signed [16:0] b_ext_r;

  // side data after stage 1
  logic [delay_width-1:0] ddata_p1;

  // **********************************************************************
  // multiply
  // **********************************************************************

  always_ff @(posedge clk) begin
    // stage 1
    a_ext_r <= {data_a[15], data_a};
    b_ext_r <= {data_b[15], data_b};
    // stage 2
    // 17x17 signed fits the 34 bit product
    data_p  <= a_ext_r * b_ext_r;
  end

  // **********************************************************************
  // side data delay
  // **********************************************************************

  // carries the valid strobe on the i path
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ddata_p1  <= '0;
      ddata_out <= '0;
    end else begin
      ddata_p1  <= ddata_in;
      ddata_out <= ddata_p1;
    end
  end

endmodule

/* rtl/dc_offset.sv */
// static dc offset stage
// adds the programmed offset to each channel when enabled
// result and strobe registered together, sums wrap at 16 bits

`timescale 1ns/1ps

module dc_offset import iq_types_pkg::*, iq_regs_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  iq_stream_t in_stream,
  input  iq_cfg_t    cfg,
  output iq_stream_t out_stream
);

  // offset sums before the register
  sample_t  sum_i;
  sample_t  sum_q;
  iq_pair_t data_nxt;

  // registered stream
  logic     valid_r;
  iq_pair_t data_r;

  // plain two's complement add
  assign sum_i = in_stream.data.i + cfg.dc_i;
  assign sum_q = in_stream.data.q + cfg.dc_q;

  // offset only when enabled
  always_comb begin
    if (cfg.dc_en) begin
      data_nxt.i = sum_i;
      data_nxt.q = sum_q;
    end else begin
      data_nxt = in_stream.data;
    end
  end

  // strobe
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_r <= 1'b0;
    end else begin
      valid_r <= in_stream.valid;
    end
  end

  // payload
  always_ff @(posedge clk) begin
    data_r <= data_nxt;
  end

  assign out_stream.valid = valid_r;
  assign out_stream.data  = data_r;

  // **********************************************************************
  // checks
  // **********************************************************************

  // one cycle from input strobe to output strobe
  // skipped on the first cycle out of reset
  assert property (@(posedge clk) disable iff (!rst_n)
    $past(rst_n) |-> (out_stream.valid == $past(in_stream.valid)));

endmodule

/* rtl/iq_corrector.sv */
// iq corrector for one output channel
// out = a*i + b*q with the pair (a, b) picked by q_or_i_n
// 4 cycle path (multiply 2, sum 1, output 1)
// own channel passed with equal latency when correction is off

`timescale 1ns/1ps

module iq_corrector import iq_types_pkg::*, iq_regs_pkg::*; #(
  parameter bit q_or_i_n     = 1'b0,
  parameter bit iqcor_bypass = 1'b0
) (
  input  logic       clk,
  input  logic       rst_n,
  input  iq_stream_t in_stream,
  input  iq_cfg_t    cfg,
  output logic       out_valid,
  output sample_t    out_data
);

  generate
    if (iqcor_bypass) begin : g_bypass

      // no pipeline at all
      assign out_valid = in_stream.valid;
      assign out_data  = q_or_i_n ? in_stream.data.q : in_stream.data.i;

    end else begin : g_corr

      // registered coefficient pair
      coeff_t  coeff_a_r;
      coeff_t  coeff_b_r;

      // multiplier outputs
      prod_t   prod_i;
      prod_t   prod_q;
      logic    mul_valid;
      sample_t mul_i;
      sample_t mul_q;

      // sum stage
      logic    sum_valid;
      prod_t   sum_p;
      sample_t sum_i;
      sample_t sum_q;

      // output stage
      logic    out_valid_r;
      sample_t out_data_r;

      // ******************************************************************
      // coefficient select
      // ******************************************************************

      // i output uses ii/iq, q output uses qi/qq
      always_ff @(posedge clk) begin
        coeff_a_r <= q_or_i_n ? cfg.coeff_qi : cfg.coeff_ii;
        coeff_b_r <= q_or_i_n ? cfg.coeff_qq : cfg.coeff_iq;
      end

      // ******************************************************************
      // products
      // ******************************************************************

      // i path also carries the strobe
      iq_mul #(.delay_width(17)) mul_i_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .data_a    (in_stream.data.i),
        .data_b    (coeff_a_r),
        .ddata_in  ({in_stream.valid, in_stream.data.i}),
        .data_p    (prod_i),
        .ddata_out ({mul_valid, mul_i})
      );

      iq_mul #(.delay_width(16)) mul_q_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .data_a    (in_stream.data.q),
        .data_b    (coeff_b_r),
        .ddata_in  (in_stream.data.q),
        .data_p    (prod_q),
        .ddata_out (mul_q)
      );

      // sum at full width
      always_ff @(posedge clk) begin
        if (!rst_n) begin
          sum_valid <= 1'b0;
        end else begin
          sum_valid <= mul_valid;
        end
        sum_p <= prod_i + prod_q;
        sum_i <= mul_i;
        sum_q <= mul_q;
      end

      // ******************************************************************
      // output
      // ******************************************************************

      // drop the fraction bits and the top guard bits
      always_ff @(posedge clk) begin
        if (!rst_n) begin
          out_valid_r <= 1'b0;
        end else begin
          out_valid_r <= sum_valid;
        end
        if (cfg.iqcor_en) begin
          out_data_r <= sum_p[COEFF_FRAC+15:COEFF_FRAC];
        end else if (q_or_i_n) begin
          out_data_r <= sum_q;
        end else begin
          out_data_r <= sum_i;
        end
      end

      assign out_valid = out_valid_r;
      assign out_data  = out_data_r;

      // strobe travels through both multiplier stages, sum and output
      assert property (@(posedge clk) disable iff (!rst_n)
        $past(in_stream.valid, 4) |-> out_valid);
      assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> $past(in_stream.valid, 4));

    end
  endgenerate

endmodule

/* rtl/rx_iq_ctrl.sv */
// iq correction register file
// seven config registers written by strobe, address and data
// combinational readback, unmapped addresses read as zero
// drives the packed config to the data path

`timescale 1ns/1ps

module rx_iq_ctrl import iq_types_pkg::*, iq_regs_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      reg_wr,
  input  reg_addr_t reg_addr,
  input  reg_data_t reg_wdata,
  output reg_data_t reg_rdata,
  output iq_cfg_t   cfg
);

  // ctrl bits
  logic    iqcor_en_r;
  logic    dc_en_r;

  // offsets
  sample_t dc_i_r;
  sample_t dc_q_r;

  // coefficient pairs
  coeff_t  coeff_ii_r;
  coeff_t  coeff_iq_r;
  coeff_t  coeff_qi_r;
  coeff_t  coeff_qq_r;

  // **********************************************************************
  // write side
  // **********************************************************************

  // everything back to zero on reset
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      iqcor_en_r <= 1'b0;
      dc_en_r    <= 1'b0;
      dc_i_r     <= '0;
      dc_q_r     <= '0;
      coeff_ii_r <= '0;
      coeff_iq_r <= '0;
      coeff_qi_r <= '0;
      coeff_qq_r <= '0;
    end else if (reg_wr && (reg_addr <= ADDR_LAST)) begin
      case (reg_addr)
        ADDR_CTRL: begin
          iqcor_en_r <= reg_wdata[CTRL_IQCOR_BIT];
          dc_en_r    <= reg_wdata[CTRL_DC_BIT];
        end
        ADDR_DC_I:     dc_i_r     <= reg_wdata;
        ADDR_DC_Q:     dc_q_r     <= reg_wdata;
        ADDR_COEFF_II: coeff_ii_r <= reg_wdata;
        ADDR_COEFF_IQ: coeff_iq_r <= reg_wdata;
        ADDR_COEFF_QI: coeff_qi_r <= reg_wdata;
        ADDR_COEFF_QQ: coeff_qq_r <= reg_wdata;
        default: ;
      endcase
    end
  end

  // **********************************************************************
  // read side
  // **********************************************************************

  always_comb begin
    reg_rdata = '0;
    case (reg_addr)
      ADDR_CTRL: begin
        reg_rdata[CTRL_IQCOR_BIT] = iqcor_en_r;
        reg_rdata[CTRL_DC_BIT]    = dc_en_r;
      end
      ADDR_DC_I:     reg_rdata = dc_i_r;
      ADDR_DC_Q:     reg_rdata = dc_q_r;
      ADDR_COEFF_II: reg_rdata = coeff_ii_r;
      ADDR_COEFF_IQ: reg_rdata = coeff_iq_r;
      ADDR_COEFF_QI: reg_rdata = coeff_qi_r;
      ADDR_COEFF_QQ: reg_rdata = coeff_qq_r;
      default:       reg_rdata = '0;
    endcase
  end

  // config out
  assign cfg.iqcor_en = iqcor_en_r;
  assign cfg.dc_en    = dc_en_r;
  assign cfg.dc_i     = dc_i_r;
  assign cfg.dc_q     = dc_q_r;
  assign cfg.coeff_ii = coeff_ii_r;
  assign cfg.coeff_iq = coeff_iq_r;
  assign cfg.coeff_qi = coeff_qi_r;
  assign cfg.coeff_qq = coeff_qq_r;

  // a write must target a known register
  assert property (@(posedge clk) disable iff (!rst_n)
    reg_wr |-> !$isunknown(reg_addr));

endmodule

/* rtl/rx_iq_top.sv */
// receive iq correction subsystem
// register file, static dc offset and one corrector per output channel
// 5 cycles from input strobe to output strobe, no back-pressure

`timescale 1ns/1ps

module rx_iq_top import iq_types_pkg::*, iq_regs_pkg::*; #(
  parameter bit iqcor_bypass = 1'b0
) (
  input  logic      clk,
  input  logic      rst_n,
  // sample input
  input  logic      in_valid,
  input  sample_t   in_i,
  input  sample_t   in_q,
  // corrected output
  output logic      out_valid,
  output sample_t   out_i,
  output sample_t   out_q,
  // register port
  input  logic      reg_wr,
  input  reg_addr_t reg_addr,
  input  reg_data_t reg_wdata,
  output reg_data_t reg_rdata
);

  iq_cfg_t    cfg;
  iq_stream_t in_stream;
  iq_stream_t dc_stream;

  // pack the input
  assign in_stream.valid  = in_valid;
  assign in_stream.data.i = in_i;
  assign in_stream.data.q = in_q;

  // **********************************************************************
  // control
  // **********************************************************************

  rx_iq_ctrl ctrl_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .reg_wr    (reg_wr),
    .reg_addr  (reg_addr),
    .reg_wdata (reg_wdata),
    .reg_rdata (reg_rdata),
    .cfg       (cfg)
  );

  // **********************************************************************
  // data path
  // **********************************************************************

  dc_offset dc_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_stream  (in_stream),
    .cfg        (cfg),
    .out_stream (dc_stream)
  );

  // i output, its strobe is the subsystem strobe
  iq_corrector #(.q_or_i_n(1'b0), .iqcor_bypass(iqcor_bypass)) corr_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_stream (dc_stream),
    .cfg       (cfg),
    .out_valid (out_valid),
    .out_data  (out_i)
  );

  // q output
  iq_corrector #(.q_or_i_n(1'b1), .iqcor_bypass(iqcor_bypass)) corr_q (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_stream (dc_stream),
    .cfg       (cfg),
    .out_valid (),
    .out_data  (out_q)
  );

endmodule

/* dv/rx_iq_tb.sv */
// testbench for the receive iq correction subsystem
// directed tests of registers, bypass, dc offset and correction
// expected samples come from a reference model of the correction rule

`timescale 1ns/1ps

module rx_iq_tb import iq_types_pkg::*, iq_regs_pkg::*;;

  localparam int     CLK_PERIOD    = 100;
  localparam int     LATENCY       = 5;
  localparam int     SEED          = 80729;
  localparam int     NUM_TESTS     = 6;
  // bypass 48, dc 24, correction 64, identity 16
  localparam int     TOTAL_SAMPLES = 152;
  localparam longint WATCHDOG_NS   = longint'((TOTAL_SAMPLES + 50 * NUM_TESTS) * CLK_PERIOD);

  logic      clk = 1'b0;
  logic      rst_n;
  logic      in_valid;
  sample_t   in_i;
  sample_t   in_q;
  logic      out_valid;
  sample_t   out_i;
  sample_t   out_q;
  logic      reg_wr;
  reg_addr_t reg_addr;
  reg_data_t reg_wdata;
  reg_data_t reg_rdata;

  // register contents as the model sees them, 7..15 stay zero
  reg_data_t shadow [16];
  // expected outputs and the cycle each input was seen
  iq_pair_t  exp_q[$];
  int        stamp_q[$];
  iq_pair_t  exp_pair;
  int        stamp;
  int        cyc = 0;
  int        errors = 0;

  rx_iq_top #(.iqcor_bypass(1'b0)) dut_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_i      (in_i),
    .in_q      (in_q),
    .out_valid (out_valid),
    .out_i     (out_i),
    .out_q     (out_q),
    .reg_wr    (reg_wr),
    .reg_addr  (reg_addr),
    .reg_wdata (reg_wdata),
    .reg_rdata (reg_rdata)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  always @(posedge clk) cyc <= cyc + 1;

  // **********************************************************************
  // helpers
  // **********************************************************************

  task automatic check_val(input string name, input logic [15:0] got, input logic [15:0] exp);
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %s got 0x%04h expected 0x%04h", name, got, exp);
    end
  endtask

  function automatic logic [15:0] rnd16();
    logic [31:0] r;
    r = $urandom();
    return r[15:0];
  endfunction

  // reference rule: dc add with wrap, then a*i' + b*q' bits 29..14
  function automatic sample_t ref_out(input sample_t i, input sample_t q, input bit q_chan);
    sample_t ip;
    sample_t qp;
    coeff_t  ca;
    coeff_t  cb;
    longint  a;
    longint  b;
    longint  x;
    longint  y;
    longint  s;
    ip = i;
    qp = q;
    if (shadow[ADDR_CTRL][CTRL_DC_BIT]) begin
      ip = i + shadow[ADDR_DC_I];
      qp = q + shadow[ADDR_DC_Q];
    end
    if (!shadow[ADDR_CTRL][CTRL_IQCOR_BIT]) begin
      return q_chan ? qp : ip;
    end
    ca = q_chan ? shadow[ADDR_COEFF_QI] : shadow[ADDR_COEFF_II];
    cb = q_chan ? shadow[ADDR_COEFF_QQ] : shadow[ADDR_COEFF_IQ];
    a = ca;
    b = cb;
    x = ip;
    y = qp;
    s = a * x + b * y;
    return s[29:14];
  endfunction

  // ctrl reads back only its two enable bits
  function automatic reg_data_t expected_rdata(input reg_addr_t addr);
    reg_data_t d;
    d = shadow[addr];
    if (addr == ADDR_CTRL) begin
      d = '0;
      d[CTRL_IQCOR_BIT] = shadow[ADDR_CTRL][CTRL_IQCOR_BIT];
      d[CTRL_DC_BIT]    = shadow[ADDR_CTRL][CTRL_DC_BIT];
    end
    return d;
  endfunction

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      in_valid <= 1'b0;
      reg_wr   <= 1'b0;
    end
  endtask

  // back-to-back calls keep reg_wr high, idle() drops it
  task automatic write_reg(input reg_addr_t addr, input reg_data_t data);
    @(posedge clk);
    reg_wr    <= 1'b1;
    reg_addr  <= addr;
    reg_wdata <= data;
    if (addr <= ADDR_LAST) begin
      shadow[addr] = data;
    end
  endtask

  task automatic read_check(input reg_addr_t addr);
    @(posedge clk);
    reg_wr   <= 1'b0;
    reg_addr <= addr;
    @(negedge clk);
    check_val($sformatf("reg_rdata[%0d]", addr), reg_rdata, expected_rdata(addr));
  endtask

  task automatic send_raw(input sample_t i, input sample_t q, input iq_pair_t e);
    @(posedge clk);
    in_valid <= 1'b1;
    in_i     <= i;
    in_q     <= q;
    exp_q.push_back(e);
  endtask

  task automatic send_sample(input sample_t i, input sample_t q);
    iq_pair_t e;
    e.i = ref_out(i, q, 1'b0);
    e.q = ref_out(i, q, 1'b1);
    send_raw(i, q, e);
  endtask

  // watchdog ends the run if the pipe never empties
  task automatic drain();
    idle(1);
    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
  endtask

  // **********************************************************************
  // output monitor
  // **********************************************************************

  always @(negedge clk) begin
    if (rst_n) begin
      if (stamp_q.size() != 0 && cyc - stamp_q[0] > LATENCY) begin
        errors++;
        $display("out_valid missing for the sample that entered at cycle %0d", stamp_q[0]);
        void'(stamp_q.pop_front());
        void'(exp_q.pop_front());
      end
      if (out_valid) begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("out_valid high at cycle %0d with no sample in flight", cyc);
        end else begin
          exp_pair = exp_q.pop_front();
          stamp    = stamp_q.pop_front();
          if (cyc - stamp != LATENCY) begin
            errors++;
            $display("sample from cycle %0d came out after %0d cycles", stamp, cyc - stamp);
          end
          check_val("out_i", out_i, exp_pair.i);
          check_val("out_q", out_q, exp_pair.q);
        end
      end
      if (in_valid) begin
        stamp_q.push_back(cyc);
      end
    end
  end

  // **********************************************************************
  // tests
  // **********************************************************************

  // quiet output, all registers zero
  task automatic test_reset();
    idle(10);
    for (int a = 0; a <= ADDR_LAST; a++) begin
      read_check(4'(a));
    end
  endtask

  task automatic test_regs();
    for (int a = 0; a <= ADDR_LAST; a++) begin
      write_reg(4'(a), rnd16());
    end
    idle(1);
    // unmapped, must not land anywhere
    write_reg(4'd9, 16'hffff);
    idle(1);
    for (int a = 0; a <= 9; a++) begin
      read_check(4'(a));
    end
    idle(8);
  endtask

  task automatic test_bypass();
    write_reg(ADDR_CTRL, 16'h0000);
    idle(8);
    repeat (24) send_sample(rnd16(), rnd16());
    drain();
    repeat (24) begin
      send_sample(rnd16(), rnd16());
      idle($urandom_range(2, 0));
    end
    drain();
  endtask

  task automatic test_dc();
    for (int r = 0; r < 3; r++) begin
      write_reg(ADDR_CTRL, 16'h0002);
      // first round forces both channels past full scale
      write_reg(ADDR_DC_I, (r == 0) ? 16'h7fff : rnd16());
      write_reg(ADDR_DC_Q, (r == 0) ? 16'h8001 : rnd16());
      idle(8);
      send_sample(16'h7fff, 16'h8000);
      repeat (7) send_sample(rnd16(), rnd16());
      drain();
    end
  endtask

  task automatic test_corr();
    sample_t si [32];
    sample_t sq [32];
    reg_data_t ii;
    reg_data_t iq;
    write_reg(ADDR_CTRL, 16'h0003);
    write_reg(ADDR_DC_I, rnd16());
    write_reg(ADDR_DC_Q, rnd16());
    for (int a = ADDR_COEFF_II; a <= ADDR_COEFF_QQ; a++) begin
      write_reg(4'(a), rnd16());
    end
    idle(8);
    for (int n = 0; n < 32; n++) begin
      si[n] = rnd16();
      sq[n] = rnd16();
      send_sample(si[n], sq[n]);
    end
    drain();
    // swap the i and q coefficient pairs, same samples again
    ii = shadow[ADDR_COEFF_II];
    iq = shadow[ADDR_COEFF_IQ];
    write_reg(ADDR_COEFF_II, shadow[ADDR_COEFF_QI]);
    write_reg(ADDR_COEFF_IQ, shadow[ADDR_COEFF_QQ]);
    write_reg(ADDR_COEFF_QI, ii);
    write_reg(ADDR_COEFF_QQ, iq);
    idle(8);
    for (int n = 0; n < 32; n++) begin
      send_sample(si[n], sq[n]);
    end
    drain();
  endtask

  // 0x4000 is unity with 14 fraction bits
  task automatic test_identity();
    iq_pair_t e;
    write_reg(ADDR_CTRL, 16'h0001);
    write_reg(ADDR_COEFF_II, 16'h4000);
    write_reg(ADDR_COEFF_IQ, 16'h0000);
    write_reg(ADDR_COEFF_QI, 16'h0000);
    write_reg(ADDR_COEFF_QQ, 16'h4000);
    idle(8);
    repeat (16) begin
      e.i = rnd16();
      e.q = rnd16();
      send_raw(e.i, e.q, e);
    end
    drain();
  endtask

  initial begin
    void'($urandom(SEED));
    for (int a = 0; a < 16; a++) begin
      shadow[a] = '0;
    end
    rst_n     = 1'b0;
    in_valid  = 1'b0;
    in_i      = '0;
    in_q      = '0;
    reg_wr    = 1'b0;
    reg_addr  = '0;
    reg_wdata = '0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    test_reset();
    test_regs();
    test_bypass();
    test_dc();
    test_corr();
    test_identity();
    idle(4);
    $display("run finished with %0d errors", errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    errors++;
    $display("watchdog expired after %0d ns, the run stalled", WATCHDOG_NS);
    $display("run finished with %0d errors", errors);
    $display("TEST FAIL");
    $finish;
  end

endmodule

/* rx_iq_top.f */
rtl/iq_types_pkg.sv
rtl/iq_regs_pkg.sv
rtl/iq_mul.sv
rtl/dc_offset.sv
rtl/iq_corrector.sv
rtl/rx_iq_ctrl.sv
rtl/rx_iq_top.sv
dv/rx_iq_tb.sv

/* run_sim.sh */
#!/bin/sh
# build rx_iq_tb with verilator, run it, and judge the result from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -j 0 --top-module rx_iq_tb -f rx_iq_top.f \
  -o rx_iq_sim > sim.log 2>&1 \
  && ./obj_dir/rx_iq_sim >> sim.log 2>&1 \
  || echo "simulation build or run failed" >> sim.log
cat sim.log
grep -qx "TEST PASS" sim.log && exit 0 || exit 1
